//--- hw/record_fifo.sv
// ######################################################################
// Record FIFO
// Circular buffer of records, full and empty flags, sticky overflow
// when a write arrives while full
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

module record_fifo
    import sniffer_pkg::*;
#(
    parameter integer DEPTH = 16
) (
    input  wire        clk_ULPI,
    input  wire        rst,
    input  wire        wr_en,
    input  record_t    wr_rec,
    input  wire        rd_en,
    output record_t    rd_rec,      // Head record, valid when not empty
    output logic       empty,
    output logic       full,
    output logic       overflow     // Held until reset
);

    localparam integer AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    record_t        mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;      // Occupancy 0..DEPTH
    logic           do_wr;
    logic           do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
            if (wr_en && full)
                overflow <= 1'b1;   // Record lost
        end
    end

    always_ff @(posedge clk_ULPI) begin
        if (do_wr)
            mem[wr_ptr] <= wr_rec;
    end

    assign rd_rec = mem[rd_ptr];
    assign empty  = (count == '0);
    assign full   = (count == (AW+1)'(DEPTH));

endmodule

`default_nettype wire

//--- hw/record_framer.sv
// ######################################################################
// Record framer
// Turns decoder and capture strobes into FIFO records, then pops the
// FIFO and feeds tag and value bytes to the UART
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

module record_framer
    import sniffer_pkg::*;
(
    input  wire        clk_ULPI,
    input  wire        rst,
    // Decoder side
    input  wire        rxcmd_strobe,
    input  rxcmd_t     rxcmd,
    // Capture side
    input  wire        data_strobe,
    input  wire  [7:0] data_byte,
    input  wire        end_strobe,
    input  wire  [7:0] pkt_len,
    // FIFO
    output logic       wr_en,
    output record_t    wr_rec,
    output logic       rd_en,
    input  record_t    rd_rec,
    input  wire        empty,
    // UART
    output logic [7:0] tx_byte,
    output logic       tx_start,
    input  wire        tx_busy
);

    typedef enum logic [2:0] {
        FR_IDLE,        // Waiting for a record
        FR_TAG,         // Start the tag byte
        FR_WAIT_TAG,
        FR_VALUE,       // Start the value byte
        FR_WAIT_VALUE
    } fr_state_e;

    fr_state_e state;
    record_t   cur_rec;     // Record being sent

    // One record per strobe, end outranks RxCMD outranks data
    always_ff @(posedge clk_ULPI) begin
        if (!rst)
            wr_en <= 1'b0;
        else
            wr_en <= end_strobe || rxcmd_strobe || data_strobe;
    end

    always_ff @(posedge clk_ULPI) begin
        if (end_strobe) begin
            wr_rec.kind  <= REC_END;
            wr_rec.value <= pkt_len;
        end else if (rxcmd_strobe) begin
            wr_rec.kind  <= REC_RXCMD;
            wr_rec.value <= {1'b0, rxcmd};  // Same bit layout as the RxCMD
        end else if (data_strobe) begin
            wr_rec.kind  <= REC_DATA;
            wr_rec.value <= data_byte;
        end
    end

    // Send side
    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state <= FR_IDLE;
        end else begin
            case (state)
                FR_IDLE:       if (!empty) state <= FR_TAG;   // Popped this cycle
                FR_TAG:        state <= FR_WAIT_TAG;
                FR_WAIT_TAG:   if (!tx_busy) state <= FR_VALUE;
                FR_VALUE:      state <= FR_WAIT_VALUE;
                FR_WAIT_VALUE: if (!tx_busy) state <= FR_IDLE;
                default:       state <= FR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_ULPI) begin
        if (rd_en)
            cur_rec <= rd_rec;  // Latch head as it leaves
    end

    assign rd_en    = (state == FR_IDLE) && !empty;
    assign tx_start = (state == FR_TAG) || (state == FR_VALUE);
    assign tx_byte  = (state == FR_VALUE) ? cur_rec.value : cur_rec.kind;

endmodule

`default_nettype wire

//--- hw/sniffer_pkg.sv
// ######################################################################
// Shared types for the ULPI bus sniffer
// Record kinds (UART tag bytes), RxCMD event codes, RxCMD and record
// structs, default UART bit period and FIFO depth
// ######################################################################

`default_nettype none

package sniffer_pkg;

    // Record kind, the value doubles as the tag byte on the UART
    typedef enum logic [7:0] {
        REC_RXCMD = 8'hC1,      // RxCMD changed
        REC_DATA  = 8'hD2,      // One USB data byte
        REC_END   = 8'hE3       // Packet ended, value is its length
    } rec_kind_e;

    // RxCMD bits 5..4
    typedef enum logic [1:0] {
        EV_NONE      = 2'd0,
        EV_ACTIVE    = 2'd1,    // RxActive
        EV_HOST_DISC = 2'd2,    // Host disconnect
        EV_ERROR     = 2'd3     // RxActive with RxError
    } rx_event_e;

    // Decoded RxCMD, laid out so that it matches RxCMD bits 6..0
    typedef struct packed {
        logic      id;          // Bit 6
        rx_event_e rx_event;    // Bits 5..4
        logic [1:0] vbus_state; // Bits 3..2
        logic [1:0] line_state; // Bits 1..0
    } rxcmd_t;

    // One queued record, sent as kind then value
    typedef struct packed {
        rec_kind_e  kind;
        logic [7:0] value;
    } record_t;

    // 60 MHz / 65 is about 921600 baud
    localparam integer DEF_CLKS_PER_BIT = 65;

    // Records held while the UART drains
    localparam integer DEF_FIFO_DEPTH = 16;

endpackage

`default_nettype wire

//--- hw/uart_tx.sv
// ######################################################################
// UART transmitter, 8N1, LSB first
// Bit period set by CLKS_PER_BIT, busy from start bit to stop bit end
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter integer CLKS_PER_BIT = 65
) (
    input  wire        clk_ULPI,
    input  wire        rst,
    input  wire  [7:0] tx_byte,
    input  wire        tx_start,    // Taken only while idle
    output logic       tx_busy,
    output logic       uart_tx      // Idles high
);

    localparam integer CW = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e      state;
    logic [CW-1:0]  clk_cnt;    // Cycles into the current bit
    logic [2:0]     bit_idx;
    logic [7:0]     shift_q;
    logic           bit_end;

    assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= 3'd0;
            uart_tx <= 1'b1;
        end else begin
            clk_cnt <= (state == TX_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: if (tx_start) begin
                    uart_tx <= 1'b0;            // Start bit next cycle
                    shift_q <= tx_byte;
                    state   <= TX_START;
                end
                TX_START: if (bit_end) begin
                    uart_tx <= shift_q[0];
                    shift_q <= shift_q >> 1;
                    bit_idx <= 3'd0;
                    state   <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    if (bit_idx == 3'd7) begin
                        uart_tx <= 1'b1;        // Stop bit
                        state   <= TX_STOP;
                    end else begin
                        uart_tx <= shift_q[0];
                        shift_q <= shift_q >> 1;
                        bit_idx <= bit_idx + 3'd1;
                    end
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign tx_busy = (state != TX_IDLE);

endmodule

`default_nettype wire

//--- hw/ulpi_packet_capture.sv
// ######################################################################
// ULPI packet capture
// Forwards USB data bytes with a strobe, counts them and reports the
// saturated packet length once the PHY drops dir
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

module ulpi_packet_capture (
    input  wire        clk_ULPI,
    input  wire        rst,
    input  wire        dir,
    input  wire        nxt,
    input  wire  [7:0] data,
    output logic       data_strobe,     // One cycle per data byte
    output logic [7:0] data_byte,
    output logic       end_strobe,      // One cycle per finished packet
    output logic [7:0] pkt_len
);

    logic       dir_q;      // Registered bus pins
    logic       nxt_q;
    logic [7:0] data_q;
    logic       dir_prev;
    logic       in_pkt;     // At least one data byte since last end
    logic [7:0] byte_cnt;
    logic       data_hit;
    logic       end_hit;

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            dir_q    <= 1'b0;
            nxt_q    <= 1'b0;
            dir_prev <= 1'b0;
        end else begin
            dir_q    <= dir;
            nxt_q    <= nxt;
            dir_prev <= dir_q;
        end
    end

    always_ff @(posedge clk_ULPI) begin
        data_q <= data;
    end

    assign data_hit = dir_q && dir_prev && nxt_q;  // Turnaround skipped
    assign end_hit  = !dir_q && in_pkt;             // Bus handed back

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            data_strobe <= 1'b0;
            end_strobe  <= 1'b0;
            in_pkt      <= 1'b0;
            byte_cnt    <= 8'd0;
        end else begin
            data_strobe <= data_hit;
            end_strobe  <= end_hit;
            if (data_hit) begin
                in_pkt <= 1'b1;
                if (byte_cnt != 8'hFF)
                    byte_cnt <= byte_cnt + 8'd1;    // Saturate at 255
            end else if (end_hit) begin
                in_pkt   <= 1'b0;
                byte_cnt <= 8'd0;                   // Ready for next packet
            end
        end
    end

    // Payload registers, qualified by the strobes
    always_ff @(posedge clk_ULPI) begin
        if (data_hit)
            data_byte <= data_q;
        if (end_hit)
            pkt_len <= byte_cnt;
    end

endmodule

`default_nettype wire

//--- hw/ulpi_rxcmd_decoder.sv
// ######################################################################
// ULPI RxCMD decoder
// Picks RxCMD bytes off the PHY-driven bus, decodes the fields and
// strobes only when the decoded value changes
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

module ulpi_rxcmd_decoder
    import sniffer_pkg::*;
(
    input  wire        clk_ULPI,
    input  wire        rst,
    input  wire        dir,
    input  wire        nxt,
    input  wire  [7:0] data,
    output logic       rxcmd_strobe,    // One cycle per changed RxCMD
    output rxcmd_t     rxcmd,           // Last stored RxCMD
    output logic       rx_active        // Stored event is RxActive
);

    logic       dir_q;      // Registered bus pins
    logic       nxt_q;
    logic [6:0] data_q;     // Bit 7 carries no RxCMD field
    logic       dir_prev;   // dir_q one cycle earlier
    logic       have_cmd;   // An RxCMD was stored since reset
    logic       cmd_valid;
    rxcmd_t     cmd_new;

    // Input stage, turnaround spotted from dir_q vs dir_prev
    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            dir_q    <= 1'b0;
            nxt_q    <= 1'b0;
            dir_prev <= 1'b0;
        end else begin
            dir_q    <= dir;
            nxt_q    <= nxt;
            dir_prev <= dir_q;
        end
    end

    always_ff @(posedge clk_ULPI) begin
        data_q <= data[6:0];
    end

    // PHY owns the bus for two cycles and nxt low means RxCMD
    assign cmd_valid = dir_q && dir_prev && !nxt_q;
    assign cmd_new   = rxcmd_t'(data_q);

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            rxcmd_strobe <= 1'b0;
            have_cmd     <= 1'b0;
            rxcmd        <= '0;
        end else begin
            rxcmd_strobe <= 1'b0;
            if (cmd_valid && (!have_cmd || (cmd_new != rxcmd))) begin
                rxcmd        <= cmd_new;    // Keep for the next compare
                have_cmd     <= 1'b1;
                rxcmd_strobe <= 1'b1;
            end
        end
    end

    assign rx_active = have_cmd && (rxcmd.rx_event == EV_ACTIVE);

endmodule

`default_nettype wire

//--- hw/usb_sniffer_top.sv
// ######################################################################
// Receive-only USB sniffer top level
// RxCMD decoder and packet capture on the ULPI bus, record framer,
// record FIFO and UART transmitter
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

module usb_sniffer_top
    import sniffer_pkg::*;
#(
    parameter integer CLKS_PER_BIT = DEF_CLKS_PER_BIT,
    parameter integer FIFO_DEPTH   = DEF_FIFO_DEPTH
) (
    input  wire        clk_ULPI,        // 60 MHz from the PHY
    input  wire        rst,
    input  wire        ulpi_dir,
    input  wire        ulpi_nxt,
    input  wire  [7:0] ulpi_data,       // Input half of the data bus
    output logic       ulpi_stp,
    output logic       uart_tx,
    output logic       led_rx_active,
    output logic       led_overflow
);

    logic       rxcmd_strobe;
    rxcmd_t     rxcmd;
    logic       data_strobe, end_strobe;
    logic [7:0] data_byte, pkt_len;
    logic       wr_en, rd_en, empty;
    record_t    wr_rec, rd_rec;
    logic [7:0] tx_byte;
    logic       tx_start, tx_busy;

    assign ulpi_stp = 1'b0;     // Never ends a PHY transfer

    ulpi_rxcmd_decoder u_decoder (
        .clk_ULPI(clk_ULPI), .rst(rst), .dir(ulpi_dir), .nxt(ulpi_nxt), .data(ulpi_data),
        .rxcmd_strobe(rxcmd_strobe), .rxcmd(rxcmd), .rx_active(led_rx_active)
    );

    ulpi_packet_capture u_capture (
        .clk_ULPI(clk_ULPI), .rst(rst), .dir(ulpi_dir), .nxt(ulpi_nxt), .data(ulpi_data),
        .data_strobe(data_strobe), .data_byte(data_byte),
        .end_strobe(end_strobe), .pkt_len(pkt_len)
    );

    record_framer u_framer (
        .clk_ULPI(clk_ULPI), .rst(rst),
        .rxcmd_strobe(rxcmd_strobe), .rxcmd(rxcmd),
        .data_strobe(data_strobe), .data_byte(data_byte),
        .end_strobe(end_strobe), .pkt_len(pkt_len),
        .wr_en(wr_en), .wr_rec(wr_rec), .rd_en(rd_en), .rd_rec(rd_rec), .empty(empty),
        .tx_byte(tx_byte), .tx_start(tx_start), .tx_busy(tx_busy)
    );

    // Full only matters inside the FIFO, the framer never stalls
    record_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_ULPI(clk_ULPI), .rst(rst), .wr_en(wr_en), .wr_rec(wr_rec),
        .rd_en(rd_en), .rd_rec(rd_rec), .empty(empty), .full(), .overflow(led_overflow)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
        .clk_ULPI(clk_ULPI), .rst(rst), .tx_byte(tx_byte), .tx_start(tx_start),
        .tx_busy(tx_busy), .uart_tx(uart_tx)
    );

endmodule

`default_nettype wire

//--- sources.f
hw/sniffer_pkg.sv
hw/ulpi_rxcmd_decoder.sv
hw/ulpi_packet_capture.sv
hw/record_fifo.sv
hw/record_framer.sv
hw/uart_tx.sv
hw/usb_sniffer_top.sv
test/tb_usb_sniffer.sv

//--- test/tb_usb_sniffer.sv
// ######################################################################
// Testbench for the USB sniffer top level
// Table of ULPI bus steps, reference record model, UART receiver,
// LED checks and an overflow burst
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_usb_sniffer
    import sniffer_pkg::*;
();

    localparam integer CPB      = 4;     // UART bit period in clocks
    localparam integer DEPTH    = 16;
    localparam integer N_STEPS  = 21;
    localparam integer B_FIRST  = 16;    // First step of the burst phase
    localparam integer PRE_IDLE = 20;    // Idle check right after reset
    localparam integer QUIET    = 120;   // High clocks that mean the line drained

    typedef struct packed {
        logic        dir;
        logic        nxt;
        logic        rnd;       // Fresh LCG byte every cycle
        logic        sync;      // Let the UART catch up, then check the LED
        logic        exp_led;   // led_rx_active at the sync point
        logic [7:0]  data;
        logic [15:0] hold;      // Cycles this step is driven
    } step_t;

    logic        clk_ULPI;
    logic        rst;
    logic        ulpi_dir;
    logic        ulpi_nxt;
    logic [7:0]  ulpi_data;
    wire         ulpi_stp;
    wire         uart_tx;
    wire         led_rx_active;
    wire         led_overflow;

    step_t       steps [N_STEPS];
    record_t     exp_q [$];         // Reference model output
    record_t     got_q [$];         // Records seen on the line
    int unsigned lcg_state = 12116;
    int          n_err = 0;
    int          n_chk = 0;
    int          limit = 0;
    bit          burst_mode = 1'b0; // Records no longer compared one by one
    logic        m_prev_dir = 1'b0; // Model state
    logic        m_have = 1'b0;
    logic [6:0]  m_last = '0;
    logic        m_in_pkt = 1'b0;
    logic [7:0]  m_cnt = '0;

    usb_sniffer_top #(.CLKS_PER_BIT(CPB), .FIFO_DEPTH(DEPTH)) dut (
        .clk_ULPI(clk_ULPI), .rst(rst), .ulpi_dir(ulpi_dir), .ulpi_nxt(ulpi_nxt),
        .ulpi_data(ulpi_data), .ulpi_stp(ulpi_stp), .uart_tx(uart_tx),
        .led_rx_active(led_rx_active), .led_overflow(led_overflow)
    );

    initial begin
        clk_ULPI = 1'b0;
        forever #2 clk_ULPI = ~clk_ULPI;  // 4 ns period
    end

    function automatic step_t mk_step(input logic d, input logic n, input logic r,
                                      input logic s, input logic led,
                                      input logic [7:0] b, input int h);
        step_t st;
        st.dir     = d;
        st.nxt     = n;
        st.rnd     = r;
        st.sync    = s;
        st.exp_led = led;
        st.data    = b;
        st.hold    = 16'(h);
        return st;
    endfunction

    function automatic record_t mk_rec(input rec_kind_e k, input logic [7:0] v);
        record_t r;
        r.kind  = k;
        r.value = v;
        return r;
    endfunction

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];    // Upper bits, better spread
    endfunction

    //                   dir nxt rnd syn led data  hold
    task automatic load_table();
        steps[0]  = mk_step(0, 0, 0, 0, 0, 8'h00, 5);   // Idle bus
        steps[1]  = mk_step(1, 0, 0, 0, 0, 8'h55, 1);   // Turnaround, byte ignored
        steps[2]  = mk_step(1, 0, 0, 0, 0, 8'h00, 3);   // First RxCMD all zero plus repeats
        steps[3]  = mk_step(1, 0, 0, 0, 0, 8'h80, 2);   // Bit 7 only, no change
        steps[4]  = mk_step(1, 0, 0, 1, 0, 8'h01, 1);   // Line state change
        steps[5]  = mk_step(0, 0, 0, 0, 0, 8'h00, 3);   // No data, so no end record
        steps[6]  = mk_step(1, 0, 0, 0, 0, 8'h5E, 1);
        steps[7]  = mk_step(1, 0, 0, 1, 1, 8'h5D, 2);   // RxActive
        steps[8]  = mk_step(1, 1, 1, 0, 0, 8'h00, 6);
        steps[9]  = mk_step(1, 0, 0, 0, 0, 8'h5D, 1);   // Repeat inside packet
        steps[10] = mk_step(1, 1, 1, 0, 0, 8'h00, 3);
        steps[11] = mk_step(1, 0, 0, 1, 0, 8'h4D, 1);   // RxActive dropped
        steps[12] = mk_step(0, 0, 0, 1, 0, 8'h00, 4);   // End, 9 bytes
        steps[13] = mk_step(1, 0, 0, 0, 0, 8'h00, 1);
        steps[14] = mk_step(1, 0, 0, 1, 0, 8'h6D, 2);   // Host disconnect
        steps[15] = mk_step(0, 0, 0, 0, 0, 8'h00, 3);
        steps[16] = mk_step(1, 0, 0, 0, 0, 8'h00, 1);   // Burst phase
        steps[17] = mk_step(1, 0, 0, 0, 0, 8'h5D, 1);
        steps[18] = mk_step(1, 1, 1, 0, 0, 8'h00, 40);  // Back-to-back data
        steps[19] = mk_step(1, 0, 0, 0, 0, 8'h4D, 1);
        steps[20] = mk_step(0, 0, 0, 0, 0, 8'h00, 4);
    endtask

    // Expected records for one bus cycle
    task automatic model_cycle(input logic d, input logic n, input logic [7:0] b);
        logic valid;
        valid = d && m_prev_dir;    // First PHY cycle is turnaround
        if (valid && !n && (!m_have || b[6:0] != m_last)) begin
            exp_q.push_back(mk_rec(REC_RXCMD, {1'b0, b[6:0]}));
            m_last = b[6:0];
            m_have = 1'b1;
        end
        if (valid && n) begin
            exp_q.push_back(mk_rec(REC_DATA, b));
            m_in_pkt = 1'b1;
            if (m_cnt != 8'hFF)
                m_cnt = m_cnt + 8'd1;  // Saturating length
        end
        if (!d && m_in_pkt) begin
            exp_q.push_back(mk_rec(REC_END, m_cnt));
            m_in_pkt = 1'b0;
            m_cnt    = 8'd0;
        end
        m_prev_dir = d;
    endtask

    task automatic drive_cycle(input step_t st);
        logic [7:0] b;
        @(negedge clk_ULPI);
        b = st.rnd ? next_rand() : st.data;
        ulpi_dir  = st.dir;
        ulpi_nxt  = st.nxt;
        ulpi_data = b;
        model_cycle(st.dir, st.nxt, b);
    endtask

    // Hold the step until every expected record came out
    task automatic catch_up(input step_t st);
        while (got_q.size() < exp_q.size())
            drive_cycle(st);
        n_chk++;
        if (led_rx_active !== st.exp_led) begin
            $display("ERR %0t: led_rx_active %b, expected %b", $time,
                     led_rx_active, st.exp_led);
            n_err++;
        end
    endtask

    task automatic read_uart_byte(output logic [7:0] b);
        repeat (CPB/2 - 1) @(negedge clk_ULPI); // Middle of start bit
        for (int k = 0; k < 8; k++) begin
            repeat (CPB) @(negedge clk_ULPI);
            b[k] = uart_tx;                     // LSB first
        end
        repeat (CPB) @(negedge clk_ULPI);
        if (uart_tx !== 1'b1) begin
            $display("ERR %0t: stop bit low on the UART line", $time);
            n_err++;
        end
    endtask

    // UART receiver, tag byte then value byte
    initial begin : uart_monitor
        logic [7:0] tag;
        logic [7:0] val;
        record_t    r;
        int         idx;
        forever begin
            @(negedge clk_ULPI);
            if (rst === 1'b1 && uart_tx === 1'b0) begin
                read_uart_byte(tag);
                @(negedge clk_ULPI);
                while (uart_tx !== 1'b0)
                    @(negedge clk_ULPI);
                read_uart_byte(val);
                r   = mk_rec(rec_kind_e'(tag), val);
                idx = got_q.size();
                if (!burst_mode) begin
                    n_chk++;
                    if (idx >= exp_q.size()) begin
                        $display("ERR %0t: unexpected record %h %h", $time, tag, val);
                        n_err++;
                    end else if (r !== exp_q[idx]) begin
                        $display("ERR %0t: record %0d got %h %h, expected %h %h", $time,
                                 idx, tag, val, exp_q[idx].kind, exp_q[idx].value);
                        n_err++;
                    end
                end
                got_q.push_back(r);
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (limit > 0);
        while (cycles <= limit) begin
            @(posedge clk_ULPI);
            cycles++;
        end
        $display("Timeout, run still going after %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int n_a;
        int quiet;
        int k;
        int tcyc;
        rst       = 1'b0;
        ulpi_dir  = 1'b0;
        ulpi_nxt  = 1'b0;
        ulpi_data = 8'h00;
        load_table();
        tcyc = 3 + PRE_IDLE + QUIET;
        for (int i = 0; i < N_STEPS; i++)
            tcyc += steps[i].hold;
        // At most one record per table cycle, 2 bytes of 10 bits each
        limit = 2 * (tcyc + tcyc * 2 * 10 * CPB);
        repeat (3) @(negedge clk_ULPI);
        rst = 1'b1;

        repeat (PRE_IDLE) begin
            @(negedge clk_ULPI);
            n_chk++;
            if (uart_tx !== 1'b1 || led_overflow !== 1'b0 || led_rx_active !== 1'b0 ||
                ulpi_stp !== 1'b0) begin
                $display("ERR %0t: outputs not idle after reset", $time);
                n_err++;
            end
        end

        n_a = 0;
        for (int i = 0; i < N_STEPS; i++) begin
            if (i == B_FIRST) begin
                n_a = exp_q.size();
                burst_mode = 1'b1;
                n_chk++;
                if (led_overflow !== 1'b0) begin
                    $display("ERR %0t: overflow set before the burst", $time);
                    n_err++;
                end
            end
            repeat (steps[i].hold)
                drive_cycle(steps[i]);
            if (steps[i].sync)
                catch_up(steps[i]);
        end

        quiet = 0;
        while (quiet < QUIET) begin
            @(negedge clk_ULPI);
            quiet = (uart_tx === 1'b1) ? quiet + 1 : 0;
        end

        n_chk++;
        if (led_overflow !== 1'b1) begin
            $display("ERR %0t: overflow not set by the burst", $time);
            n_err++;
        end
        n_chk++;
        if (got_q.size() < n_a + DEPTH) begin
            $display("ERR %0t: only %0d burst records received", $time, got_q.size() - n_a);
            n_err++;
        end else begin
            for (int j = n_a; j < n_a + DEPTH; j++) begin
                if (got_q[j] !== exp_q[j]) begin
                    $display("ERR %0t: burst record %0d got %h, expected %h", $time, j,
                             got_q[j], exp_q[j]);
                    n_err++;
                end
            end
        end
        k = n_a;                        // Walk the expected list in order
        for (int j = n_a; j < got_q.size(); j++) begin
            while (k < exp_q.size() && exp_q[k] !== got_q[j])
                k++;
            n_chk++;
            if (k >= exp_q.size()) begin
                $display("ERR %0t: burst record %0d out of order or unknown", $time, j);
                n_err++;
            end else begin
                k++;
            end
        end

        $display("Checks: %0d, errors: %0d, records received: %0d", n_chk, n_err,
                 got_q.size());
        if (n_err == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
